/* hdl/sdhc_reg_pkg.sv */
`default_nettype none

package sdhc_reg_pkg;

   localparam int ADDR_W = 12;
   localparam int DATA_W = 32;

   // setup registers written by the CPU and read back unchanged.
   localparam logic [ADDR_W-1:0] REG_BLKSIZE  = 12'h004;
   localparam logic [ADDR_W-1:0] REG_BLKCNT   = 12'h006;
   localparam logic [ADDR_W-1:0] REG_ARG      = 12'h008;
   localparam logic [ADDR_W-1:0] REG_XFERMODE = 12'h00C;
   localparam logic [ADDR_W-1:0] REG_CMD      = 12'h00E;

   // status words produced by the command engine.
   localparam logic [ADDR_W-1:0] REG_RESP      = 12'h010;
   localparam logic [ADDR_W-1:0] REG_PRESENT   = 12'h024;
   localparam logic [ADDR_W-1:0] REG_NORM_STAT = 12'h030;
   localparam logic [ADDR_W-1:0] REG_ERR_STAT  = 12'h032;

   // present-state bits.
   localparam int PRES_CMD_INHIBIT = 0;

   // normal-status bits.
   localparam int NSTAT_CMD_DONE = 0;

   // error-status bits.
   localparam int ESTAT_TIMEOUT = 0;
   localparam int ESTAT_CRC     = 1;
   localparam int ESTAT_END     = 2;
   localparam int ESTAT_INDEX   = 3;

endpackage

`default_nettype wire

/* hdl/sdhc_cmd_pkg.sv */
`default_nettype none

package sdhc_cmd_pkg;

   // a command or short response is 48 bits on the CMD line.
   localparam int FRAME_BITS = 48;

   // field positions inside a frame, counted from the end bit at 0.
   localparam int FR_IDX_LSB     = 40;
   localparam int FR_PAYLOAD_LSB = 8;
   localparam int FR_CRC_LSB     = 1;

   // the CRC covers the first 40 bits sent.
   localparam int CRC_W          = 7;
   localparam int CRC_COVER_BITS = 40;
   localparam logic [CRC_W-1:0] CRC7_POLY = 7'h09;

   // command register layout.
   localparam int CMD_IDX_LSB   = 8;
   localparam int CMD_IDX_W     = 6;
   localparam int RESP_TYPE_LSB = 0;
   localparam int RESP_TYPE_W   = 2;

   localparam logic [RESP_TYPE_W-1:0] RESP_TYPE_NONE = 2'b00;
   localparam logic [RESP_TYPE_W-1:0] RESP_TYPE_48   = 2'b10;

   // bit periods allowed before the response start bit.
   localparam int RESP_TIMEOUT_BITS = 64;

endpackage

`default_nettype wire

/* hdl/sdhc_crc7.sv */
`default_nettype none

module sdhc_crc7 (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       clear,
   input  logic       bit_en,
   input  logic       bit_in,
   output logic [6:0] crc
);

   import sdhc_cmd_pkg::*;

   logic feedback;

   assign feedback = crc[CRC_W-1] ^ bit_in;

   // the register holds the remainder of the bits seen so far, msb first.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         crc <= '0;
      end else if (clear) begin
         crc <= '0;
      end else if (bit_en) begin
         crc <= {crc[CRC_W-2:0], 1'b0} ^ (feedback ? CRC7_POLY : '0);
      end
   end

endmodule

`default_nettype wire

/* hdl/sdhc_regs.sv */
`default_nettype none

module sdhc_regs (
   input  logic                            clk,
   input  logic                            arst_n,
   input  logic                            req,
   input  logic                            wr_valid,
   input  logic [sdhc_reg_pkg::ADDR_W-1:0] addrs,
   input  logic [sdhc_reg_pkg::DATA_W-1:0] wr_data,
   output logic [sdhc_reg_pkg::DATA_W-1:0] rd_data,
   output logic                            acknowledge,
   output logic [sdhc_reg_pkg::DATA_W-1:0] blk_size,
   output logic [sdhc_reg_pkg::DATA_W-1:0] blk_count,
   output logic [sdhc_reg_pkg::DATA_W-1:0] xfer_mode,
   output logic [sdhc_reg_pkg::DATA_W-1:0] cmd_arg,
   output logic [sdhc_reg_pkg::DATA_W-1:0] cmd_word,
   output logic                            cmd_start,
   input  logic [sdhc_reg_pkg::DATA_W-1:0] resp_word,
   input  logic [sdhc_reg_pkg::DATA_W-1:0] norm_stat,
   input  logic [sdhc_reg_pkg::DATA_W-1:0] err_stat,
   input  logic                            cmd_busy
);

   import sdhc_reg_pkg::*;

   logic [DATA_W-1:0] present_word;
   logic [DATA_W-1:0] rd_next;
   logic              wr_en;
   logic              rd_en;

   assign wr_en = req & wr_valid;
   assign rd_en = req & ~wr_valid;

   always_comb begin
      present_word = '0;
      present_word[PRES_CMD_INHIBIT] = cmd_busy;
   end

   // unmapped addresses read as zero.
   always_comb begin
      case (addrs)
         REG_BLKSIZE:   rd_next = blk_size;
         REG_BLKCNT:    rd_next = blk_count;
         REG_ARG:       rd_next = cmd_arg;
         REG_XFERMODE:  rd_next = xfer_mode;
         REG_CMD:       rd_next = cmd_word;
         REG_RESP:      rd_next = resp_word;
         REG_PRESENT:   rd_next = present_word;
         REG_NORM_STAT: rd_next = norm_stat;
         REG_ERR_STAT:  rd_next = err_stat;
         default:       rd_next = '0;
      endcase
   end

   // every request is answered one clock later, mapped or not.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         acknowledge <= 1'b0;
         cmd_start   <= 1'b0;
         rd_data     <= '0;
      end else begin
         acknowledge <= req;
         cmd_start   <= wr_en && (addrs == REG_CMD);
         if (rd_en) begin
            rd_data <= rd_next;
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         blk_size  <= '0;
         blk_count <= '0;
         cmd_arg   <= '0;
         xfer_mode <= '0;
         cmd_word  <= '0;
      end else if (wr_en) begin
         case (addrs)
            REG_BLKSIZE:  blk_size  <= wr_data;
            REG_BLKCNT:   blk_count <= wr_data;
            REG_ARG:      cmd_arg   <= wr_data;
            REG_XFERMODE: xfer_mode <= wr_data;
            REG_CMD:      cmd_word  <= wr_data;
            default:      ;
         endcase
      end
   end

endmodule

`default_nettype wire

/* hdl/sdhc_cmd_ctrl.sv */
`default_nettype none

module sdhc_cmd_ctrl #(
   parameter int SD_CLK_DIV = 4
) (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        cmd_start,
   input  logic [31:0] cmd_arg,
   input  logic [31:0] cmd_word,
   output logic [31:0] resp_word,
   output logic [31:0] norm_stat,
   output logic [31:0] err_stat,
   output logic        cmd_busy,
   output logic        sd_cmd_out,
   output logic        sd_cmd_oe,
   input  logic        sd_cmd_in
);

   import sdhc_reg_pkg::*;
   import sdhc_cmd_pkg::*;

   localparam int DIV_W   = (SD_CLK_DIV > 1) ? $clog2(SD_CLK_DIV) : 1;
   localparam int CNT_MAX = (FRAME_BITS > RESP_TIMEOUT_BITS) ? FRAME_BITS : RESP_TIMEOUT_BITS;
   localparam int CNT_W   = $clog2(CNT_MAX);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_SEND,
      ST_WAIT,
      ST_RECV,
      ST_FINISH
   } state_t;

   state_t                 state;
   logic [DIV_W-1:0]       div_cnt;
   logic [CNT_W-1:0]       bit_cnt;
   logic                   bit_first;
   logic                   bit_tick;
   logic                   mid_tick;
   logic                   start_accept;
   logic [FRAME_BITS-1:0]  tx_shift;
   logic [FRAME_BITS-1:0]  tx_next;
   logic [FRAME_BITS-1:0]  rx_shift;
   logic [FRAME_BITS-1:0]  rx_frame;
   logic [CMD_IDX_W-1:0]   cmd_idx;
   logic [RESP_TYPE_W-1:0] resp_type;
   logic [CRC_W-1:0]       tx_crc;
   logic [CRC_W-1:0]       rx_crc;
   logic                   tx_crc_en;
   logic                   rx_crc_en;

   assign bit_first    = (div_cnt == '0);
   assign bit_tick     = (div_cnt == DIV_W'(SD_CLK_DIV - 1));
   assign mid_tick     = (div_cnt == DIV_W'(SD_CLK_DIV / 2));
   assign start_accept = (state == ST_IDLE) && cmd_start;
   assign cmd_busy     = (state != ST_IDLE);
   assign rx_frame     = {rx_shift[FRAME_BITS-2:0], sd_cmd_in};

   // each bit is fed to the generator in the first clock of its period, so
   // the remainder is ready before the last covered bit ends.
   assign tx_crc_en = (state == ST_SEND) && bit_first && (bit_cnt < CNT_W'(CRC_COVER_BITS));
   assign rx_crc_en = mid_tick && (((state == ST_WAIT) && !sd_cmd_in) ||
                                   ((state == ST_RECV) && (bit_cnt < CNT_W'(CRC_COVER_BITS))));

   always_comb begin
      tx_next = {tx_shift[FRAME_BITS-2:0], 1'b0};
      if (bit_cnt == CNT_W'(CRC_COVER_BITS - 1)) begin
         tx_next[FRAME_BITS-1 -: CRC_W] = tx_crc;
      end
   end

   sdhc_crc7 i_tx_crc (
      .clk    (clk),
      .arst_n (arst_n),
      .clear  (start_accept),
      .bit_en (tx_crc_en),
      .bit_in (sd_cmd_out),
      .crc    (tx_crc)
   );

   sdhc_crc7 i_rx_crc (
      .clk    (clk),
      .arst_n (arst_n),
      .clear  (start_accept),
      .bit_en (rx_crc_en),
      .bit_in (sd_cmd_in),
      .crc    (rx_crc)
   );

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         div_cnt <= '0;
      end else if ((state == ST_IDLE) || bit_tick) begin
         div_cnt <= '0;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   // frame and response shift registers.
   always_ff @(posedge clk) begin
      if (start_accept) begin
         tx_shift  <= {1'b0, 1'b1, cmd_word[CMD_IDX_LSB +: CMD_IDX_W], cmd_arg,
                       {CRC_W{1'b0}}, 1'b1};
         cmd_idx   <= cmd_word[CMD_IDX_LSB +: CMD_IDX_W];
         resp_type <= cmd_word[RESP_TYPE_LSB +: RESP_TYPE_W];
      end else if ((state == ST_SEND) && bit_tick) begin
         tx_shift <= tx_next;
      end
      if (mid_tick && ((state == ST_WAIT) || (state == ST_RECV))) begin
         rx_shift <= rx_frame;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state      <= ST_IDLE;
         bit_cnt    <= '0;
         sd_cmd_out <= 1'b1;
         sd_cmd_oe  <= 1'b0;
         resp_word  <= '0;
         norm_stat  <= '0;
         err_stat   <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (start_accept) begin
                  state      <= ST_SEND;
                  bit_cnt    <= '0;
                  sd_cmd_out <= 1'b0;
                  sd_cmd_oe  <= 1'b1;
                  norm_stat  <= '0;
                  err_stat   <= '0;
               end
            end
            ST_SEND: begin
               if (bit_tick) begin
                  if (bit_cnt == CNT_W'(FRAME_BITS - 1)) begin
                     sd_cmd_out <= 1'b1;
                     sd_cmd_oe  <= 1'b0;
                     bit_cnt    <= '0;
                     state      <= (resp_type == RESP_TYPE_48) ? ST_WAIT : ST_FINISH;
                  end else begin
                     sd_cmd_out <= tx_next[FRAME_BITS-1];
                     bit_cnt    <= bit_cnt + 1'b1;
                  end
               end
            end
            ST_WAIT: begin
               if (mid_tick) begin
                  if (!sd_cmd_in) begin
                     state   <= ST_RECV;
                     bit_cnt <= CNT_W'(1);
                  end else if (bit_cnt == CNT_W'(RESP_TIMEOUT_BITS - 1)) begin
                     err_stat[ESTAT_TIMEOUT] <= 1'b1;
                     state                   <= ST_FINISH;
                  end else begin
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               end
            end
            ST_RECV: begin
               if (mid_tick) begin
                  if (bit_cnt == CNT_W'(FRAME_BITS - 1)) begin
                     resp_word             <= rx_frame[FR_PAYLOAD_LSB +: 32];
                     err_stat[ESTAT_CRC]   <= (rx_frame[FR_CRC_LSB +: CRC_W] != rx_crc);
                     err_stat[ESTAT_END]   <= ~rx_frame[0];
                     err_stat[ESTAT_INDEX] <= (rx_frame[FR_IDX_LSB +: CMD_IDX_W] != cmd_idx);
                     state                 <= ST_FINISH;
                  end else begin
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               end
            end
            ST_FINISH: begin
               norm_stat[NSTAT_CMD_DONE] <= 1'b1;
               state                     <= ST_IDLE;
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* hdl/sdhc_top.sv */
`default_nettype none

module sdhc_top #(
   parameter int SD_CLK_DIV = 4
) (
   input  logic                            clk,
   input  logic                            arst_n,
   input  logic                            req,
   input  logic                            wr_valid,
   input  logic [sdhc_reg_pkg::ADDR_W-1:0] addrs,
   input  logic [sdhc_reg_pkg::DATA_W-1:0] wr_data,
   output logic [sdhc_reg_pkg::DATA_W-1:0] rd_data,
   output logic                            acknowledge,
   output logic [sdhc_reg_pkg::DATA_W-1:0] blk_size,
   output logic [sdhc_reg_pkg::DATA_W-1:0] blk_count,
   output logic [sdhc_reg_pkg::DATA_W-1:0] xfer_mode,
   output logic                            sd_cmd_out,
   output logic                            sd_cmd_oe,
   input  logic                            sd_cmd_in
);

   import sdhc_reg_pkg::*;

   logic [DATA_W-1:0] cmd_arg;
   logic [DATA_W-1:0] cmd_word;
   logic [DATA_W-1:0] resp_word;
   logic [DATA_W-1:0] norm_stat;
   logic [DATA_W-1:0] err_stat;
   logic              cmd_start;
   logic              cmd_busy;

   sdhc_regs i_regs (
      .clk         (clk),
      .arst_n      (arst_n),
      .req         (req),
      .wr_valid    (wr_valid),
      .addrs       (addrs),
      .wr_data     (wr_data),
      .rd_data     (rd_data),
      .acknowledge (acknowledge),
      .blk_size    (blk_size),
      .blk_count   (blk_count),
      .xfer_mode   (xfer_mode),
      .cmd_arg     (cmd_arg),
      .cmd_word    (cmd_word),
      .cmd_start   (cmd_start),
      .resp_word   (resp_word),
      .norm_stat   (norm_stat),
      .err_stat    (err_stat),
      .cmd_busy    (cmd_busy)
   );

   sdhc_cmd_ctrl #(
      .SD_CLK_DIV (SD_CLK_DIV)
   ) i_cmd_ctrl (
      .clk        (clk),
      .arst_n     (arst_n),
      .cmd_start  (cmd_start),
      .cmd_arg    (cmd_arg),
      .cmd_word   (cmd_word),
      .resp_word  (resp_word),
      .norm_stat  (norm_stat),
      .err_stat   (err_stat),
      .cmd_busy   (cmd_busy),
      .sd_cmd_out (sd_cmd_out),
      .sd_cmd_oe  (sd_cmd_oe),
      .sd_cmd_in  (sd_cmd_in)
   );

endmodule

`default_nettype wire

/* verif/sdhc_sva.sv */
`default_nettype none

module sdhc_sva (
   input logic                            clk,
   input logic                            arst_n,
   input logic                            req,
   input logic                            wr_valid,
   input logic [sdhc_reg_pkg::ADDR_W-1:0] addrs,
   input logic                            acknowledge,
   input logic                            cmd_start,
   input logic                            cmd_busy,
   input logic                            sd_cmd_oe
);

   import sdhc_reg_pkg::*;

   ack_follows_req: assert property (@(posedge clk) disable iff (!arst_n)
      acknowledge == $past(req))
      else $error("acknowledge is not exactly one cycle after req");

   start_after_cmd_write: assert property (@(posedge clk) disable iff (!arst_n)
      cmd_start |-> $past(req && wr_valid && (addrs == REG_CMD)))
      else $error("cmd_start without a preceding command register write");

   // the CMD line is only driven while a command is active.
   oe_only_when_busy: assert property (@(posedge clk) disable iff (!arst_n)
      !cmd_busy |-> !sd_cmd_oe)
      else $error("sd_cmd_oe high while cmd_busy is low");

endmodule

`default_nettype wire

/* verif/sdhc_checker.sv */
`default_nettype none

module sdhc_checker #(
   parameter int CLK_DIV = 4
) (
   input logic                            clk,
   input logic                            arst_n,
   input logic                            req,
   input logic                            wr_valid,
   input logic [sdhc_reg_pkg::ADDR_W-1:0] addrs,
   input logic [sdhc_reg_pkg::DATA_W-1:0] wr_data,
   input logic [sdhc_reg_pkg::DATA_W-1:0] rd_data,
   input logic                            acknowledge,
   input logic [sdhc_reg_pkg::DATA_W-1:0] blk_size,
   input logic [sdhc_reg_pkg::DATA_W-1:0] blk_count,
   input logic [sdhc_reg_pkg::DATA_W-1:0] xfer_mode,
   input logic                            sd_cmd_out,
   input logic                            sd_cmd_oe,
   input logic                            poll,
   input logic [1:0]                      card_mode,
   input logic [31:0]                     card_status
);

   import sdhc_reg_pkg::*;
   import sdhc_cmd_pkg::*;

   string       test_name = "";
   int          errors = 0;
   int          pass_count = 0;
   int          fail_count = 0;
   logic [31:0] sh_blksize, sh_blkcnt, sh_arg, sh_xfer, sh_cmd;
   logic [31:0] exp_resp, exp_norm, exp_err;
   logic [31:0] fin_resp, fin_norm, fin_err;
   logic [31:0] rd_exp, exp_arg;
   logic [11:0] rd_addr;
   logic [5:0]  exp_idx;
   logic [47:0] frame;
   logic        pending, frame_due, ack_due, rd_due, rd_poll;
   int          ph;
   int          nbits;

   function automatic logic [6:0] crc7_ref(input logic [39:0] d);
      logic [6:0] c;
      logic       fb;
      c = '0;
      for (int i = 39; i >= 0; i--) begin
         fb = c[6] ^ d[i];
         c = {c[5:0], 1'b0} ^ (fb ? CRC7_POLY : 7'h00);
      end
      return c;
   endfunction

   // mode 0 is a good answer, 1 a bad CRC, 2 a wrong index, 3 silence.
   function automatic logic [31:0] err_ref(input logic [1:0] rtype, input logic [1:0] mode);
      logic [31:0] e;
      e = '0;
      if (rtype == RESP_TYPE_48) begin
         case (mode)
            2'd1: e[ESTAT_CRC] = 1'b1;
            2'd2: e[ESTAT_INDEX] = 1'b1;
            2'd3: e[ESTAT_TIMEOUT] = 1'b1;
            default: ;
         endcase
      end
      return e;
   endfunction

   function automatic logic [31:0] read_ref(input logic [11:0] a);
      case (a)
         REG_BLKSIZE:   return sh_blksize;
         REG_BLKCNT:    return sh_blkcnt;
         REG_ARG:       return sh_arg;
         REG_XFERMODE:  return sh_xfer;
         REG_CMD:       return sh_cmd;
         REG_RESP:      return exp_resp;
         REG_PRESENT:   return {31'b0, pending};
         REG_NORM_STAT: return exp_norm;
         REG_ERR_STAT:  return exp_err;
         default:       return '0;
      endcase
   endfunction

   task mismatch(input string what, input logic [47:0] exp_v, input logic [47:0] act_v);
      $display("Error %s %s expected %h actual %h", test_name, what, exp_v, act_v);
      errors++;
   endtask

   task begin_test(input string name);
      test_name = name;
      errors = 0;
   endtask

   task finish_test();
      if (frame_due) begin
         $display("%s: the command frame that was expected never appeared", test_name);
         errors++;
         frame_due = 1'b0;
      end
      if (errors == 0) begin
         $display("ok    %s", test_name);
         pass_count++;
      end else begin
         $display("FAIL  %s with %0d errors", test_name, errors);
         fail_count++;
      end
   endtask

   task write_shadow();
      case (addrs)
         REG_BLKSIZE:  sh_blksize = wr_data;
         REG_BLKCNT:   sh_blkcnt = wr_data;
         REG_ARG:      sh_arg = wr_data;
         REG_XFERMODE: sh_xfer = wr_data;
         REG_CMD: begin
            sh_cmd = wr_data;
            // a write while a command runs is stored but starts nothing.
            if (!pending) begin
               pending = 1'b1;
               frame_due = 1'b1;
               exp_idx = wr_data[CMD_IDX_LSB +: 6];
               exp_arg = sh_arg;
               exp_norm = '0;
               exp_err = '0;
               fin_norm = 32'h1;
               fin_err = err_ref(wr_data[1:0], card_mode);
               fin_resp = (wr_data[1:0] == RESP_TYPE_48 && card_mode != 2'd3) ?
                          card_status : exp_resp;
            end
         end
         default: ;
      endcase
   endtask

   // bus side, sampled on the rising edge before the DUT updates.
   always @(posedge clk) begin
      if (!arst_n) begin
         {sh_blksize, sh_blkcnt, sh_arg, sh_xfer, sh_cmd} = '0;
         {exp_resp, exp_norm, exp_err} = '0;
         {pending, frame_due, ack_due, rd_due, rd_poll} = '0;
      end else begin
         if (acknowledge !== ack_due) begin
            mismatch("acknowledge", 48'(ack_due), 48'(acknowledge));
         end
         // the setup registers leave the block for the data path.
         if (blk_size !== sh_blksize) begin
            mismatch("blk_size", 48'(sh_blksize), 48'(blk_size));
         end
         if (blk_count !== sh_blkcnt) begin
            mismatch("blk_count", 48'(sh_blkcnt), 48'(blk_count));
         end
         if (xfer_mode !== sh_xfer) begin
            mismatch("xfer_mode", 48'(sh_xfer), 48'(xfer_mode));
         end
         if (ack_due && rd_due) begin
            if (rd_poll) begin
               if (pending && !rd_data[PRES_CMD_INHIBIT]) begin
                  pending = 1'b0;
                  exp_resp = fin_resp;
                  exp_norm = fin_norm;
                  exp_err = fin_err;
               end
            end else if (rd_data !== rd_exp) begin
               mismatch($sformatf("read %03h", rd_addr), 48'(rd_exp), 48'(rd_data));
            end
         end
         ack_due = req;
         rd_due = req && !wr_valid;
         rd_poll = poll;
         rd_addr = addrs;
         rd_exp = read_ref(addrs);
         if (req && wr_valid) begin
            write_shadow();
         end
      end
   end

   // CMD line side, each bit sampled one clock into its period.
   always @(negedge clk) begin
      if (!arst_n || !sd_cmd_oe) begin
         if (arst_n && ph != 0 && ph != FRAME_BITS * CLK_DIV) begin
            $display("%s: sd_cmd_oe was high for %0d clocks instead of %0d",
                     test_name, ph, FRAME_BITS * CLK_DIV);
            errors++;
         end
         ph = 0;
         nbits = 0;
      end else begin
         if (ph % CLK_DIV == 1) begin
            frame = {frame[46:0], sd_cmd_out};
            nbits++;
            if (nbits == FRAME_BITS) begin
               if (!frame_due) begin
                  $display("%s: a command frame was sent without an accepted command",
                           test_name);
                  errors++;
               end else if (frame !== {2'b01, exp_idx, exp_arg,
                                      crc7_ref({2'b01, exp_idx, exp_arg}), 1'b1}) begin
                  mismatch("frame", {2'b01, exp_idx, exp_arg,
                                     crc7_ref({2'b01, exp_idx, exp_arg}), 1'b1}, frame);
               end
               frame_due = 1'b0;
            end
         end
         ph++;
      end
   end

endmodule

`default_nettype wire

/* verif/tb_sdhc.sv */
`default_nettype none

module tb_sdhc;

   import sdhc_reg_pkg::*;
   import sdhc_cmd_pkg::*;

   localparam int CLK_DIV = 4;

   logic              clk;
   logic              arst_n;
   logic              req;
   logic              wr_valid;
   logic [11:0]       addrs;
   logic [31:0]       wr_data;
   logic [31:0]       rd_data;
   logic              acknowledge;
   logic [31:0]       blk_size, blk_count, xfer_mode;
   logic              sd_cmd_out, sd_cmd_oe, sd_cmd_in;
   logic              poll;
   logic [1:0]        card_mode;
   logic [31:0]       card_status;
   logic [31:0]       seed;
   logic [31:0]       rd_q;

   sdhc_top #(.SD_CLK_DIV(CLK_DIV)) i_dut (
      .clk(clk), .arst_n(arst_n), .req(req), .wr_valid(wr_valid), .addrs(addrs),
      .wr_data(wr_data), .rd_data(rd_data), .acknowledge(acknowledge),
      .blk_size(blk_size), .blk_count(blk_count), .xfer_mode(xfer_mode),
      .sd_cmd_out(sd_cmd_out), .sd_cmd_oe(sd_cmd_oe), .sd_cmd_in(sd_cmd_in)
   );

   sdhc_checker #(.CLK_DIV(CLK_DIV)) i_chk (
      .clk(clk), .arst_n(arst_n), .req(req), .wr_valid(wr_valid), .addrs(addrs),
      .wr_data(wr_data), .rd_data(rd_data), .acknowledge(acknowledge),
      .blk_size(blk_size), .blk_count(blk_count), .xfer_mode(xfer_mode),
      .sd_cmd_out(sd_cmd_out), .sd_cmd_oe(sd_cmd_oe), .poll(poll),
      .card_mode(card_mode), .card_status(card_status)
   );

   bind sdhc_top sdhc_sva i_sva (
      .clk(clk), .arst_n(arst_n), .req(req), .wr_valid(wr_valid), .addrs(addrs),
      .acknowledge(acknowledge), .cmd_start(cmd_start), .cmd_busy(cmd_busy),
      .sd_cmd_oe(sd_cmd_oe)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function logic [31:0] next_rand();
      seed = seed ^ (seed << 13);
      seed = seed ^ (seed >> 17);
      seed = seed ^ (seed << 5);
      return seed;
   endfunction

   task timeout_fail(input string what);
      $display("timeout: %s", what);
      $display("tests failed");
      $finish;
   endtask

   task automatic bus_access(input logic wr, input logic [11:0] a, input logic [31:0] d);
      int n;
      n = 0;
      @(negedge clk);
      req = 1'b1;
      wr_valid = wr;
      addrs = a;
      wr_data = d;
      @(negedge clk);
      req = 1'b0;
      while (!acknowledge && n < 16) begin
         @(negedge clk);
         n++;
      end
      if (!acknowledge) timeout_fail("no acknowledge on the CPU bus");
      rd_q = rd_data;
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      poll = 1'b1;
      bus_access(1'b0, REG_PRESENT, '0);
      while (rd_q[PRES_CMD_INHIBIT] && n < 600) begin
         bus_access(1'b0, REG_PRESENT, '0);
         n++;
      end
      poll = 1'b0;
      if (rd_q[PRES_CMD_INHIBIT]) timeout_fail("the command engine stayed busy");
   endtask

   // card model: decodes the frame and answers as the mode asks.
   task automatic card_serve(input logic [1:0] mode, input logic [31:0] status);
      logic [47:0] fr;
      logic [39:0] head;
      logic [47:0] resp;
      int          n;
      n = 0;
      while (!sd_cmd_oe && n < 400) begin
         @(negedge clk);
         n++;
      end
      if (!sd_cmd_oe) timeout_fail("the card saw no command frame");
      for (int i = 0; i < FRAME_BITS; i++) begin
         @(negedge clk);
         fr = {fr[46:0], sd_cmd_out};
         repeat (CLK_DIV - 1) @(negedge clk);
      end
      if (mode != 2'd3) begin
         head = {2'b00, fr[45:40] ^ ((mode == 2'd2) ? 6'h01 : 6'h00), status};
         resp = {head, i_chk.crc7_ref(head) ^ ((mode == 2'd1) ? 7'h01 : 7'h00), 1'b1};
         repeat (2 * CLK_DIV) @(negedge clk);
         for (int i = FRAME_BITS - 1; i >= 0; i--) begin
            sd_cmd_in = resp[i];
            repeat (CLK_DIV) @(negedge clk);
         end
         sd_cmd_in = 1'b1;
      end
   endtask

   task automatic run_cmd(input string name, input logic [1:0] rtype,
                          input logic [1:0] mode, input logic twice);
      logic [31:0] arg;
      logic [31:0] word;
      arg = next_rand();
      word = (next_rand() & 32'h0000_3F00) | 32'(rtype);
      card_status = next_rand();
      card_mode = mode;
      i_chk.begin_test(name);
      fork
         card_serve((rtype == RESP_TYPE_NONE) ? 2'd3 : mode, card_status);
         begin
            bus_access(1'b1, REG_ARG, arg);
            bus_access(1'b1, REG_CMD, word);
            if (twice) bus_access(1'b1, REG_CMD, word ^ 32'h0000_0100);
         end
      join
      wait_idle();
      bus_access(1'b0, REG_RESP, '0);
      bus_access(1'b0, REG_NORM_STAT, '0);
      bus_access(1'b0, REG_ERR_STAT, '0);
      bus_access(1'b0, REG_PRESENT, '0);
      i_chk.finish_test();
   endtask

   task automatic random_access();
      logic [31:0] r;
      logic [11:0] a;
      r = next_rand();
      case (r[31:28] % 9)
         0: a = REG_BLKSIZE;
         1: a = REG_BLKCNT;
         2: a = REG_ARG;
         3: a = REG_XFERMODE;
         4: a = REG_RESP;
         5: a = REG_PRESENT;
         6: a = REG_NORM_STAT;
         7: a = REG_ERR_STAT;
         default: a = REG_CMD;
      endcase
      if (r[3]) a = r[27:16];
      bus_access(r[4] && (a != REG_CMD), a, next_rand());
   endtask

   initial begin
      arst_n = 1'b0;
      req = 1'b0;
      wr_valid = 1'b0;
      addrs = '0;
      wr_data = '0;
      sd_cmd_in = 1'b1;
      poll = 1'b0;
      card_mode = '0;
      card_status = '0;
      seed = 32'h7d39_d626;
      repeat (10) @(negedge clk);
      arst_n = 1'b1;
      i_chk.begin_test("register_access");
      repeat (80) random_access();
      i_chk.finish_test();
      run_cmd("cmd_no_response", RESP_TYPE_NONE, 2'd0, 1'b0);
      run_cmd("cmd_response_ok", RESP_TYPE_48, 2'd0, 1'b0);
      run_cmd("cmd_bad_crc", RESP_TYPE_48, 2'd1, 1'b0);
      run_cmd("cmd_bad_index", RESP_TYPE_48, 2'd2, 1'b0);
      run_cmd("cmd_timeout", RESP_TYPE_48, 2'd3, 1'b0);
      run_cmd("cmd_write_while_busy", RESP_TYPE_48, 2'd3, 1'b1);
      run_cmd("cmd_clears_errors", RESP_TYPE_48, 2'd0, 1'b0);
      $display("%0d tests run, %0d passed, %0d failed",
               i_chk.pass_count + i_chk.fail_count, i_chk.pass_count, i_chk.fail_count);
      if (i_chk.fail_count == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
hdl/sdhc_reg_pkg.sv
hdl/sdhc_cmd_pkg.sv
hdl/sdhc_crc7.sv
hdl/sdhc_regs.sv
hdl/sdhc_cmd_ctrl.sv
hdl/sdhc_top.sv
verif/sdhc_sva.sv
verif/sdhc_checker.sv
verif/tb_sdhc.sv

/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module tb_sdhc

sim:
	verilator --binary --timing --assert -f flist.f --top-module tb_sdhc
	./obj_dir/Vtb_sdhc > sim.log 2>&1 || echo "simulation exited early: tests failed" >> sim.log
	cat sim.log
	! grep -q "tests failed" sim.log

clean:
	rm -rf obj_dir sim.log
